// File: rtl/sens_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_io_settings.svh"

module sens_ctrl_regs (
    input  wire                     mclk,
    input  wire                     async_prst_with_sens_mrst,
    input  wire                     we_i,            // one cycle strobe from slave
    input  wire [`SENS_DAT_W-1:0]   wdata_i,
    input  wire                     trigger_mode_i,  // 0 = free running
    input  wire                     trig_i,          // external trigger
    output sens_io_pkg::sens_ctrl_t ctrl_o
);
    import sens_io_pkg::*;

    sens_ctrl_t soft_r;                              // aro holds the soft bit here

    // each field changes only with its enable bit set
    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            soft_r <= '0;
        end else if (we_i) begin
            if (wdata_i[`SENS_CTRL_MRST + 1])
                soft_r.mrst <= wdata_i[`SENS_CTRL_MRST];
            if (wdata_i[`SENS_CTRL_ARST + 1])
                soft_r.arst <= wdata_i[`SENS_CTRL_ARST];
            if (wdata_i[`SENS_CTRL_ARO + 1])         // own enable, not mrst's
                soft_r.aro  <= wdata_i[`SENS_CTRL_ARO];
            if (wdata_i[`SENS_CTRL_GP0 + 1])
                soft_r.gp0  <= wdata_i[`SENS_CTRL_GP0];
            if (wdata_i[`SENS_CTRL_GP1 + 1])
                soft_r.gp1  <= wdata_i[`SENS_CTRL_GP1];
        end
    end

    always_comb begin
        ctrl_o     = soft_r;
        ctrl_o.aro = trigger_mode_i ? ~trig_i : soft_r.aro; // aro low while trigger high
    end

endmodule

`default_nettype wire

// File: rtl/sens_io_pkg.sv
`default_nettype none
`include "sens_io_settings.svh"

package sens_io_pkg;

    typedef enum logic [`SENS_ADR_W-1:0] {
        REG_CTRL   = 2'd0,            // sensor control pins
        REG_STATUS = 2'd1,            // read only
        REG_JTAG   = 2'd2             // external fpga port, addr 3 unused
    } sens_reg_e;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`SENS_ADR_W-1:0] adr;
        logic [`SENS_DAT_W-1:0] dat;   // write data
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`SENS_DAT_W-1:0] dat;   // read data, valid with ack
    } wb_rsp_t;

    typedef struct packed {
        logic mrst;
        logic arst;
        logic aro;                     // effective level, trigger applied
        logic gp0;
        logic gp1;
    } sens_ctrl_t;

    typedef struct packed {
        logic pgmen;
        logic prog;
        logic tck;
        logic tms;
        logic tdi;
    } sens_jtag_t;

    typedef struct packed {
        logic done;
        logic tdo;
        logic pgm_in;
    } sens_pins_t;

    typedef struct packed {
        logic force_pgm;               // prog level held after pgmen drops
    } sens_probe_t;

endpackage

`default_nettype wire

// File: rtl/sens_io_settings.svh
`ifndef SENS_IO_SETTINGS_SVH
`define SENS_IO_SETTINGS_SVH

`define SENS_ADR_W          2   // wishbone word address, 4 registers
`define SENS_DAT_W          32  // wishbone data

// control register, value bit of each field, enable is value + 1
`define SENS_CTRL_MRST      0   // sensor master reset
`define SENS_CTRL_ARST      2   // sensor array reset
`define SENS_CTRL_ARO       4   // soft aro level
`define SENS_CTRL_GP0       6
`define SENS_CTRL_GP1       8

// jtag register, same value/enable pairing
`define SENS_JTAG_TDI       0
`define SENS_JTAG_TMS       2
`define SENS_JTAG_TCK       4
`define SENS_JTAG_PROG      6   // prog_b, inverted on the pad
`define SENS_JTAG_PGMEN     8   // hands shared pins to jtag

// status word layout
`define SENS_STAT_PGM_IN    0   // sensed prog pin
`define SENS_STAT_TDO       1
`define SENS_STAT_DONE      2
`define SENS_STAT_FORCE_PGM 3   // latched prog drive
`define SENS_STAT_PGMEN     4

`define SENS_SYNC_STAGES    2   // pad input synchronizer depth

`endif

// File: rtl/sens_io_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_io_settings.svh"

module sens_io_top (
    input  wire                  mclk,
    input  wire                  async_prst_with_sens_mrst,
    input  wire sens_io_pkg::wb_req_t wb_i,
    input  wire                  trigger_mode_i,
    input  wire                  trig_i,
    input  wire                  sns_pgm_i,
    input  wire                  sns_flash_tdo_i,
    input  wire                  sns_shutter_done_i,
    output sens_io_pkg::wb_rsp_t wb_o,
    output logic                 sns_pgm_o,
    output logic                 sns_pgm_oe_o,
    output logic                 sns_ctl_tck_o,
    output logic                 sns_mrst_o,
    output logic                 sns_arst_tms_o,
    output logic                 sns_gp0_tdi_o,
    output logic                 sns_gp1_o
);
    import sens_io_pkg::*;

    logic                   ctrl_we;
    logic                   jtag_we;
    logic [`SENS_DAT_W-1:0] wdata;
    sens_ctrl_t             ctrl;
    sens_jtag_t             jtag;
    sens_pins_t             pins;
    sens_probe_t            probe;

    sens_wb_slave u_wb_slave (
        .mclk (mclk), .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .wb_i (wb_i), .ctrl_i (ctrl), .jtag_i (jtag), .pins_i (pins), .probe_i (probe),
        .wb_o (wb_o), .ctrl_we_o (ctrl_we), .jtag_we_o (jtag_we), .wdata_o (wdata)
    );

    sens_ctrl_regs u_ctrl_regs (
        .mclk (mclk), .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .we_i (ctrl_we), .wdata_i (wdata),
        .trigger_mode_i (trigger_mode_i), .trig_i (trig_i), .ctrl_o (ctrl)
    );

    sens_jtag_regs u_jtag_regs (
        .mclk (mclk), .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .we_i (jtag_we), .wdata_i (wdata), .jtag_o (jtag)
    );

    sens_pad_mux u_pad_mux (
        .mclk (mclk), .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .ctrl_i (ctrl), .jtag_i (jtag),
        .sns_pgm_i (sns_pgm_i), .sns_flash_tdo_i (sns_flash_tdo_i),
        .sns_shutter_done_i (sns_shutter_done_i),
        .pins_o (pins), .probe_o (probe),
        .sns_pgm_o (sns_pgm_o), .sns_pgm_oe_o (sns_pgm_oe_o),
        .sns_ctl_tck_o (sns_ctl_tck_o), .sns_mrst_o (sns_mrst_o),
        .sns_arst_tms_o (sns_arst_tms_o), .sns_gp0_tdi_o (sns_gp0_tdi_o),
        .sns_gp1_o (sns_gp1_o)
    );

endmodule

`default_nettype wire

// File: rtl/sens_jtag_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_io_settings.svh"

module sens_jtag_regs (
    input  wire                     mclk,
    input  wire                     async_prst_with_sens_mrst,
    input  wire                     we_i,            // one cycle strobe from slave
    input  wire [`SENS_DAT_W-1:0]   wdata_i,
    output sens_io_pkg::sens_jtag_t jtag_o
);

    // bit-banged jtag, host toggles tck by single-field writes
    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            jtag_o <= '0;                            // pgmen off, pins to sensor
        end else if (we_i) begin
            if (wdata_i[`SENS_JTAG_PGMEN + 1])
                jtag_o.pgmen <= wdata_i[`SENS_JTAG_PGMEN];
            if (wdata_i[`SENS_JTAG_PROG + 1])
                jtag_o.prog  <= wdata_i[`SENS_JTAG_PROG];
            if (wdata_i[`SENS_JTAG_TCK + 1])
                jtag_o.tck   <= wdata_i[`SENS_JTAG_TCK];
            if (wdata_i[`SENS_JTAG_TMS + 1])
                jtag_o.tms   <= wdata_i[`SENS_JTAG_TMS];
            if (wdata_i[`SENS_JTAG_TDI + 1])
                jtag_o.tdi   <= wdata_i[`SENS_JTAG_TDI];
        end
    end

endmodule

`default_nettype wire

// File: rtl/sens_pad_mux.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_io_settings.svh"

module sens_pad_mux (
    input  wire                      mclk,
    input  wire                      async_prst_with_sens_mrst,
    input  wire sens_io_pkg::sens_ctrl_t ctrl_i,
    input  wire sens_io_pkg::sens_jtag_t jtag_i,
    input  wire                      sns_pgm_i,          // prog pad, input side
    input  wire                      sns_flash_tdo_i,
    input  wire                      sns_shutter_done_i,
    output sens_io_pkg::sens_pins_t  pins_o,
    output sens_io_pkg::sens_probe_t probe_o,
    output logic                     sns_pgm_o,
    output logic                     sns_pgm_oe_o,       // 1 = pad driven
    output logic                     sns_ctl_tck_o,      // aro or tck
    output logic                     sns_mrst_o,
    output logic                     sns_arst_tms_o,     // arst or tms
    output logic                     sns_gp0_tdi_o,      // gp0 or tdi
    output logic                     sns_gp1_o
);
    import sens_io_pkg::*;

    sens_pins_t  sync_r [`SENS_SYNC_STAGES];             // pad input synchronizer
    logic [1:0]  pgmen_d;                                // pgmen history
    sens_probe_t probe_r;

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            for (int i = 0; i < `SENS_SYNC_STAGES; i++) sync_r[i] <= '0;
        end else begin
            sync_r[0] <= '{done: sns_shutter_done_i, tdo: sns_flash_tdo_i,
                           pgm_in: sns_pgm_i};
            for (int i = 1; i < `SENS_SYNC_STAGES; i++) sync_r[i] <= sync_r[i-1];
        end
    end

    assign pins_o = sync_r[`SENS_SYNC_STAGES-1];

    // probe the prog pin once jtag mode ends, then keep driving that level
    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            pgmen_d <= 2'b00;
            probe_r <= '0;
        end else begin
            pgmen_d <= {pgmen_d[0], jtag_i.pgmen};
            if (pgmen_d == 2'b10) probe_r.force_pgm <= pins_o.pgm_in; // falling edge
        end
    end

    assign probe_o = probe_r;

    assign sns_ctl_tck_o  = jtag_i.pgmen ? jtag_i.tck : ctrl_i.aro;
    assign sns_arst_tms_o = jtag_i.pgmen ? jtag_i.tms : ctrl_i.arst;
    assign sns_gp0_tdi_o  = jtag_i.pgmen ? jtag_i.tdi : ctrl_i.gp0;
    assign sns_gp1_o      = ctrl_i.gp1;                  // never shared
    assign sns_mrst_o     = ctrl_i.mrst;

    assign sns_pgm_o      = jtag_i.pgmen ? ~jtag_i.prog : probe_r.force_pgm;
    assign sns_pgm_oe_o   = jtag_i.pgmen | probe_r.force_pgm; // released to read done

endmodule

`default_nettype wire

// File: rtl/sens_wb_slave.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_io_settings.svh"

module sens_wb_slave (
    input  wire                            mclk,
    input  wire                            async_prst_with_sens_mrst,
    input  wire  sens_io_pkg::wb_req_t     wb_i,      // held by host until ack
    input  wire  sens_io_pkg::sens_ctrl_t  ctrl_i,
    input  wire  sens_io_pkg::sens_jtag_t  jtag_i,
    input  wire  sens_io_pkg::sens_pins_t  pins_i,    // already synchronized
    input  wire  sens_io_pkg::sens_probe_t probe_i,
    output sens_io_pkg::wb_rsp_t           wb_o,
    output logic                           ctrl_we_o, // sampled by bank on ack edge
    output logic                           jtag_we_o,
    output logic [`SENS_DAT_W-1:0]         wdata_o
);
    import sens_io_pkg::*;

    logic                   ack_r;
    logic                   start;                    // first cycle of an access
    sens_reg_e              reg_sel;
    logic [`SENS_DAT_W-1:0] rd_word;
    logic [`SENS_DAT_W-1:0] rdata_r;

    assign start   = wb_i.cyc & wb_i.stb & ~ack_r;    // no re-ack right after ack
    assign reg_sel = sens_reg_e'(wb_i.adr);
    assign wdata_o = wb_i.dat;

    always_comb begin
        ctrl_we_o = 1'b0;
        jtag_we_o = 1'b0;
        rd_word   = '0;                               // enable bits read as zero
        case (reg_sel)
            REG_CTRL: begin
                ctrl_we_o                  = start & wb_i.we;
                rd_word[`SENS_CTRL_MRST]   = ctrl_i.mrst;
                rd_word[`SENS_CTRL_ARST]   = ctrl_i.arst;
                rd_word[`SENS_CTRL_ARO]    = ctrl_i.aro;
                rd_word[`SENS_CTRL_GP0]    = ctrl_i.gp0;
                rd_word[`SENS_CTRL_GP1]    = ctrl_i.gp1;
            end
            REG_STATUS: begin                         // writes dropped
                rd_word[`SENS_STAT_PGM_IN]    = pins_i.pgm_in;
                rd_word[`SENS_STAT_TDO]       = pins_i.tdo;
                rd_word[`SENS_STAT_DONE]      = pins_i.done;
                rd_word[`SENS_STAT_FORCE_PGM] = probe_i.force_pgm;
                rd_word[`SENS_STAT_PGMEN]     = jtag_i.pgmen;
            end
            REG_JTAG: begin
                jtag_we_o                  = start & wb_i.we;
                rd_word[`SENS_JTAG_TDI]    = jtag_i.tdi;
                rd_word[`SENS_JTAG_TMS]    = jtag_i.tms;
                rd_word[`SENS_JTAG_TCK]    = jtag_i.tck;
                rd_word[`SENS_JTAG_PROG]   = jtag_i.prog;
                rd_word[`SENS_JTAG_PGMEN]  = jtag_i.pgmen;
            end
            default: rd_word = '0;                    // addr 3, reads zero
        endcase
    end

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) ack_r <= 1'b0;
        else                           ack_r <= start; // single wait cycle
    end

    always_ff @(posedge mclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) rdata_r <= '0;
        else if (start)                rdata_r <= rd_word; // captured with ack
    end

    assign wb_o = '{ack: ack_r, dat: rdata_r};

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with verilator, pass only on the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module sens_io_tb \
    --Mdir obj_dir

./obj_dir/Vsens_io_tb | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail"
    exit 1
fi

// File: src.f
+incdir+rtl
rtl/sens_io_pkg.sv
rtl/sens_wb_slave.sv
rtl/sens_ctrl_regs.sv
rtl/sens_jtag_regs.sv
rtl/sens_pad_mux.sv
rtl/sens_io_top.sv
tb/sens_io_properties.sv
tb/sens_io_tb.sv

// File: tb/sens_io_cases.txt
# name op adr data {trigger_mode,trig} {done,tdo,pgm_in} pads, data is write value or read expect
# {pgm,pgm_oe,tck,mrst,arst_tms,gp0_tdi,gp1} write read pins, pins ignore adr and data
rst_ctrl   read  0 00000000 00 000 0000000
rst_stat   read  1 00000000 00 000 0000000
rst_jtag   read  2 00000000 00 000 0000000
ctrl_wr1   write 0 000000c7 00 000 0001010
ctrl_rd1   read  0 00000041 00 000 0001010
ctrl_wr2   write 0 0000030c 00 000 0001111
ctrl_rd2   read  0 00000145 00 000 0001111
ctrl_wr3   write 0 00000032 00 000 0010111
ctrl_rd3   read  0 00000154 00 000 0010111
trig_hi    pins  0 00000000 11 000 0000111
trig_lo    pins  0 00000000 10 000 0010111
trig_rd    read  0 00000144 11 000 0000111
soft_aro   pins  0 00000000 01 000 0010111
jtag_on    write 2 000003fb 00 011 0110011
jtag_rd    read  2 00000151 00 011 0110011
jtag_prog  write 2 000000a0 00 011 1100011
stat_jtag  read  1 00000013 00 011 1100011
jtag_off   write 2 00000200 00 011 1110111
stat_force read  1 0000000b 00 011 1110111
pads_in    pins  0 00000000 00 100 1110111
stat_pads  read  1 0000000c 00 100 1110111
wr_status  write 1 ffffffff 00 100 1110111
wr_adr3    write 3 ffffffff 00 100 1110111
rd_adr3    read  3 00000000 00 100 1110111
ctrl_keep  read  0 00000154 00 100 1110111
jtag_on2   write 2 00000300 00 100 1100011
jtag_off2  write 2 00000200 00 100 0010111
stat_off2  read  1 00000004 00 100 0010111

// File: tb/sens_io_properties.sv
`timescale 1ns/1ps
`default_nettype none

module sens_io_properties (
    input wire                          mclk,
    input wire                          async_prst_with_sens_mrst,
    input wire sens_io_pkg::wb_req_t    wb_req_i,
    input wire sens_io_pkg::wb_rsp_t    wb_rsp_i,
    input wire sens_io_pkg::sens_jtag_t jtag_i,      // bank output inside the top
    input wire                          tck_pin_i    // shared aro / tck pad
);

    ack_in_cycle: assert property (
        @(posedge mclk) disable iff (async_prst_with_sens_mrst)
        wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb)
    ) else $error("ack raised outside a bus cycle");

    ack_single: assert property (
        @(posedge mclk) disable iff (async_prst_with_sens_mrst)
        wb_rsp_i.ack |=> !wb_rsp_i.ack                // one wait cycle, one ack
    ) else $error("ack held for two cycles");

    tck_follows_jtag: assert property (
        @(posedge mclk) disable iff (async_prst_with_sens_mrst)
        jtag_i.pgmen |-> (tck_pin_i == jtag_i.tck)
    ) else $error("tck pad not taken from jtag register while pgmen set");

endmodule

bind sens_io_top sens_io_properties u_props (
    .mclk (mclk), .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
    .wb_req_i (wb_i), .wb_rsp_i (wb_o), .jtag_i (jtag), .tck_pin_i (sns_ctl_tck_o)
);

`default_nettype wire

// File: tb/sens_io_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_io_settings.svh"

module sens_io_tb;
    import sens_io_pkg::*;

    localparam int MAX_CASES = 64;
    localparam int ACK_WAITS = 1;                    // one wait cycle before ack

    logic        mclk;
    logic        async_prst_with_sens_mrst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        trigger_mode;
    logic        trig;
    logic        pgm_in;
    logic        tdo_in;
    logic        done_in;
    logic [6:0]  pads;                               // pgm, oe, tck, mrst, tms, tdi, gp1

    logic [8*16-1:0] c_name [MAX_CASES];
    logic [8*5-1:0]  c_op   [MAX_CASES];             // write, read or pins
    logic [1:0]      c_adr  [MAX_CASES];
    logic [31:0]     c_data [MAX_CASES];             // write data or expected read
    logic [1:0]      c_tt   [MAX_CASES];             // trigger_mode, trig
    logic [2:0]      c_din  [MAX_CASES];             // done, tdo, pgm pad levels
    logic [6:0]      c_pads [MAX_CASES];
    int              n_cases = 0;
    int              rd_errs = 0;
    int              pad_errs = 0;
    int              bus_errs = 0;
    int              other_errs = 0;
    int              cycles = 0;
    int              limit = 0;                      // 0 until cases are loaded

    sens_io_top uut (
        .mclk (mclk), .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .wb_i (wb_req), .trigger_mode_i (trigger_mode), .trig_i (trig),
        .sns_pgm_i (pgm_in), .sns_flash_tdo_i (tdo_in), .sns_shutter_done_i (done_in),
        .wb_o (wb_rsp), .sns_pgm_o (pads[6]), .sns_pgm_oe_o (pads[5]),
        .sns_ctl_tck_o (pads[4]), .sns_mrst_o (pads[3]), .sns_arst_tms_o (pads[2]),
        .sns_gp0_tdi_o (pads[1]), .sns_gp1_o (pads[0])
    );

    always #20 mclk = ~mclk;                         // 40 ns period

    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the bus or a case never finished", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic load_cases();
        int              fd;
        int              cnt;
        logic [8*128-1:0] line;
        logic [8*16-1:0] name;
        logic [8*5-1:0]  op;
        logic [1:0]      adr;
        logic [31:0]     data;
        logic [1:0]      tt;
        logic [2:0]      din;
        logic [6:0]      pd;
        fd = $fopen("tb/sens_io_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/sens_io_cases.txt, no cases were run");
            other_errs++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = '0;
            if ($fgets(line, fd) == 0) break;
            cnt = $sscanf(line, "%s %s %h %h %b %b %b",
                          name, op, adr, data, tt, din, pd);
            if (cnt == 7) begin                      // header lines fall out here
                c_name[n_cases] = name;
                c_op[n_cases]   = op;
                c_adr[n_cases]  = adr;
                c_data[n_cases] = data;
                c_tt[n_cases]   = tt;
                c_din[n_cases]  = din;
                c_pads[n_cases] = pd;
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    // one classic cycle, held until ack, ack sampled mid-cycle
    task automatic bus_access(input logic [8*16-1:0] name, input logic we,
                              input logic [1:0] adr, input logic [31:0] dat,
                              output logic [31:0] rdata);
        int waits;
        waits = 0;
        @(posedge mclk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge mclk);
        while (!wb_rsp.ack) begin
            waits++;
            @(negedge mclk);
        end
        rdata = wb_rsp.dat;
        @(posedge mclk);
        wb_req <= '0;
        if (waits != ACK_WAITS) begin
            $display("ERROR %0s ack wait cycles: expected %0d, actual %0d",
                     name, ACK_WAITS, waits);
            bus_errs++;
        end
    endtask

    task automatic run_case(input int i);
        logic [31:0] rdata;
        @(posedge mclk);
        {trigger_mode, trig}     <= c_tt[i];
        {done_in, tdo_in, pgm_in} <= c_din[i];
        if (c_op[i] == 40'("write")) begin
            bus_access(c_name[i], 1'b1, c_adr[i], c_data[i], rdata);
        end else if (c_op[i] == 40'("read")) begin
            bus_access(c_name[i], 1'b0, c_adr[i], 32'h0, rdata);
            if (rdata !== c_data[i]) begin
                $display("ERROR %0s read adr %0d: expected %h, actual %h",
                         c_name[i], c_adr[i], c_data[i], rdata);
                rd_errs++;
            end
        end else if (c_op[i] != 40'("pins")) begin
            $display("case %0s has an unknown operation and was skipped", c_name[i]);
            other_errs++;
        end
        repeat (`SENS_SYNC_STAGES + 2) @(posedge mclk); // synchronizer and probe settle
        @(negedge mclk);
        if (pads !== c_pads[i]) begin
            $display("ERROR %0s pads: expected %b, actual %b", c_name[i], c_pads[i], pads);
            pad_errs++;
        end
        repeat ($urandom % 3) @(posedge mclk);       // idle gap
    endtask

    initial begin
        void'($urandom(32'hf4c0_1f62));
        mclk                      = 1'b0;
        async_prst_with_sens_mrst = 1'b1;
        wb_req                    = '0;
        trigger_mode              = 1'b0;
        trig                      = 1'b0;
        pgm_in                    = 1'b0;
        tdo_in                    = 1'b0;
        done_in                   = 1'b0;
        load_cases();
        limit = n_cases * 16 + 20;
        repeat (5) @(posedge mclk);
        async_prst_with_sens_mrst <= 1'b0;
        for (int i = 0; i < n_cases; i++) run_case(i);
        $display("%0d cases, %0d read errors, %0d pad errors, %0d bus errors, %0d other errors",
                 n_cases, rd_errs, pad_errs, bus_errs, other_errs);
        if (rd_errs + pad_errs + bus_errs + other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
